/* source/apb_pkg.sv */
`default_nettype none

package apb_pkg;

	// bus widths on the peripheral side of the bridge
	localparam int APB_ADDR_W = 16;
	localparam int APB_DATA_W = 32;

	// --------------------------------------------------------------------------
	// request, master to slave
	typedef struct packed {
		logic                  psel;
		logic                  penable;
		logic                  pwrite;
		logic [APB_ADDR_W-1:0] paddr;
		logic [APB_DATA_W-1:0] pwdata;
	} apb_req_t;

	// response, slave to master
	// pready stays high, zero wait states
	typedef struct packed {
		logic [APB_DATA_W-1:0] prdata;
		logic                  pready;
		logic                  pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

/* source/clint_pkg.sv */
`default_nettype none

package clint_pkg;

	// harts served by this block
	localparam int N_HARTS    = 2;
	localparam int HART_IDX_W = (N_HARTS > 1) ? $clog2(N_HARTS) : 1;

	// clk cycles per microsecond tick
	localparam int TICK_DIV   = 4;
	localparam int TICK_DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [TICK_DIV_W-1:0] TICK_LOAD = TICK_DIV_W'(TICK_DIV - 1);

	localparam int MTIME_W = 64;
	// no timer irq pending out of reset
	localparam logic [MTIME_W-1:0] MTIMECMP_RESET = '1;

	// --------------------------------------------------------------------------
	// register map, byte offsets
	localparam logic [15:0] REG_CTRL     = 16'h0000;
	localparam logic [15:0] REG_MTIME_LO = 16'h0008;
	localparam logic [15:0] REG_MTIME_HI = 16'h000c;
	localparam logic [15:0] HART_BASE    = 16'h0100;
	localparam logic [15:0] HART_STRIDE  = 16'h0010;
	localparam logic [15:0] HART_END     = 16'(HART_BASE + N_HARTS * HART_STRIDE);
	localparam int          HART_LSB     = $clog2(HART_STRIDE);
	localparam logic [15:0] HREG_MASK    = HART_STRIDE - 1'b1;
	// within one hart block
	localparam logic [15:0] HREG_MSIP    = 16'h0000;
	localparam logic [15:0] HREG_CMP_LO  = 16'h0008;
	localparam logic [15:0] HREG_CMP_HI  = 16'h000c;

	// --------------------------------------------------------------------------
	// strobes into one compare unit
	typedef struct packed {
		logic                           msip;
		logic                           cmp_lo;
		logic                           cmp_hi;
		logic [apb_pkg::APB_DATA_W-1:0] wdata;
	} hart_wr_t;

	// strobes into the timebase
	typedef struct packed {
		logic                           ctrl;
		logic                           lo;
		logic                           hi;
		logic [apb_pkg::APB_DATA_W-1:0] wdata;
	} tb_wr_t;

	// read source and word within it
	typedef enum logic [1:0] {SRC_NONE, SRC_CTRL, SRC_MTIME, SRC_HART} rd_src_e;
	typedef enum logic [1:0] {RSEL_BIT = 2'd0, RSEL_LO = 2'd2, RSEL_HI = 2'd3} rd_reg_e;

	typedef struct packed {
		rd_src_e               src;
		logic [HART_IDX_W-1:0] hart;
		rd_reg_e               sel;
	} rd_sel_t;

endpackage

`default_nettype wire

/* source/clint_timebase.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_timebase (
	input  logic                          clk,
	input  logic                          rst_n,
	input  clint_pkg::tb_wr_t             i_wr,
	input  logic                          i_dbg_halt,
	output logic [clint_pkg::MTIME_W-1:0] o_mtime,
	output logic                          o_enable
);

	logic [clint_pkg::TICK_DIV_W-1:0] div_q;
	logic                             run;
	logic                             tick;

	// counting only while enabled and harts not halted
	assign run  = o_enable && !i_dbg_halt;
	assign tick = run && (div_q == '0);

	// --------------------------------------------------------------------------
	// enable bit and tick divider
	// ctrl write restarts the divider, first tick TICK_DIV cycles later
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_enable <= 1'b0;
			div_q    <= clint_pkg::TICK_LOAD;
		end else if (i_wr.ctrl) begin
			o_enable <= i_wr.wdata[0];
			div_q    <= clint_pkg::TICK_LOAD;
		end else if (run) begin
			if (tick) begin
				div_q <= clint_pkg::TICK_LOAD;
			end else begin
				div_q <= div_q - 1'b1;
			end
		end
	end

	// --------------------------------------------------------------------------
	// mtime, bus writes beat the increment
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mtime <= '0;
		end else if (i_wr.lo) begin
			o_mtime[apb_pkg::APB_DATA_W-1:0] <= i_wr.wdata;
		end else if (i_wr.hi) begin
			o_mtime[clint_pkg::MTIME_W-1:apb_pkg::APB_DATA_W] <= i_wr.wdata;
		end else if (tick) begin
			// carry runs into the upper half
			o_mtime <= o_mtime + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* source/clint_hart_cmp.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_hart_cmp (
	input  logic                          clk,
	input  logic                          rst_n,
	input  clint_pkg::hart_wr_t           i_wr,
	input  logic [clint_pkg::MTIME_W-1:0] i_mtime,
	output logic [clint_pkg::MTIME_W-1:0] o_mtimecmp,
	output logic                          o_msip,
	output logic                          o_timer_irq
);

	// software irq bit, also the soft irq line
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_msip <= 1'b0;
		end else if (i_wr.msip) begin
			o_msip <= i_wr.wdata[0];
		end
	end

	// mtimecmp halves written independently
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mtimecmp <= clint_pkg::MTIMECMP_RESET;
		end else if (i_wr.cmp_lo) begin
			o_mtimecmp[apb_pkg::APB_DATA_W-1:0] <= i_wr.wdata;
		end else if (i_wr.cmp_hi) begin
			o_mtimecmp[clint_pkg::MTIME_W-1:apb_pkg::APB_DATA_W] <= i_wr.wdata;
		end
	end

	// timer irq, compare registered once
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_timer_irq <= 1'b0;
		end else begin
			o_timer_irq <= (i_mtime >= o_mtimecmp);
		end
	end

endmodule

`default_nettype wire

/* source/clint_apb_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_apb_decode (
	input  logic                                         clk,
	input  logic                                         rst_n,
	input  apb_pkg::apb_req_t                            i_apb,
	output clint_pkg::tb_wr_t                            o_tb_wr,
	output clint_pkg::hart_wr_t [clint_pkg::N_HARTS-1:0] o_hart_wr,
	output clint_pkg::rd_sel_t                           o_rd_sel,
	output logic                                         o_err
);

	logic                             setup_q;
	logic                             access;
	logic                             in_hart;
	logic [15:0]                      hart_off;
	logic [15:0]                      hreg_off;
	logic [clint_pkg::HART_IDX_W-1:0] hart_idx;

	// access phase only counts after a setup phase
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			setup_q <= 1'b0;
		end else begin
			setup_q <= i_apb.psel && !i_apb.penable;
		end
	end

	assign access = i_apb.psel && i_apb.penable && setup_q;

	// hart blocks, index and offset within block
	assign hart_off = i_apb.paddr - clint_pkg::HART_BASE;
	assign hart_idx = hart_off[clint_pkg::HART_LSB +: clint_pkg::HART_IDX_W];
	assign hreg_off = hart_off & clint_pkg::HREG_MASK;
	// hart index >= N_HARTS falls outside this range
	assign in_hart  = (i_apb.paddr >= clint_pkg::HART_BASE) &&
		(i_apb.paddr < clint_pkg::HART_END);

	// --------------------------------------------------------------------------
	// one strobe per write, one selection per read
	always_comb begin
		o_tb_wr       = '0;
		o_tb_wr.wdata = i_apb.pwdata;
		for (int h = 0; h < clint_pkg::N_HARTS; h++) begin
			o_hart_wr[h]       = '0;
			o_hart_wr[h].wdata = i_apb.pwdata;
		end
		o_rd_sel = '0;
		o_err    = 1'b0;
		if (access) begin
			if (i_apb.paddr == clint_pkg::REG_CTRL) begin
				o_tb_wr.ctrl = i_apb.pwrite;
				o_rd_sel.src = clint_pkg::SRC_CTRL;
			end else if (i_apb.paddr == clint_pkg::REG_MTIME_LO) begin
				o_tb_wr.lo   = i_apb.pwrite;
				o_rd_sel.src = clint_pkg::SRC_MTIME;
				o_rd_sel.sel = clint_pkg::RSEL_LO;
			end else if (i_apb.paddr == clint_pkg::REG_MTIME_HI) begin
				o_tb_wr.hi   = i_apb.pwrite;
				o_rd_sel.src = clint_pkg::SRC_MTIME;
				o_rd_sel.sel = clint_pkg::RSEL_HI;
			end else if (in_hart && hreg_off == clint_pkg::HREG_MSIP) begin
				o_hart_wr[hart_idx].msip = i_apb.pwrite;
				o_rd_sel.src             = clint_pkg::SRC_HART;
				o_rd_sel.sel             = clint_pkg::RSEL_BIT;
			end else if (in_hart && hreg_off == clint_pkg::HREG_CMP_LO) begin
				o_hart_wr[hart_idx].cmp_lo = i_apb.pwrite;
				o_rd_sel.src               = clint_pkg::SRC_HART;
				o_rd_sel.sel               = clint_pkg::RSEL_LO;
			end else if (in_hart && hreg_off == clint_pkg::HREG_CMP_HI) begin
				o_hart_wr[hart_idx].cmp_hi = i_apb.pwrite;
				o_rd_sel.src               = clint_pkg::SRC_HART;
				o_rd_sel.sel               = clint_pkg::RSEL_HI;
			end else begin
				// unmapped, nothing written
				o_err = 1'b1;
			end
			o_rd_sel.hart = hart_idx;
			// writes return no data
			if (i_apb.pwrite) begin
				o_rd_sel.src = clint_pkg::SRC_NONE;
			end
		end
	end

endmodule

`default_nettype wire

/* source/clint_read_mux.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_read_mux (
	input  clint_pkg::rd_sel_t                                    i_rd_sel,
	input  logic                                                  i_err,
	input  logic                                                  i_enable,
	input  logic [clint_pkg::MTIME_W-1:0]                         i_mtime,
	input  logic [clint_pkg::N_HARTS-1:0][clint_pkg::MTIME_W-1:0] i_mtimecmp,
	input  logic [clint_pkg::N_HARTS-1:0]                         i_msip,
	output apb_pkg::apb_rsp_t                                     o_apb
);

	logic [clint_pkg::MTIME_W-1:0]    cmp_sel;
	logic [apb_pkg::APB_DATA_W-1:0]   word;

	// selected hart's compare value
	assign cmp_sel = i_mtimecmp[i_rd_sel.hart];

	// zero unless a read access selects something
	always_comb begin
		word = '0;
		case (i_rd_sel.src)
			clint_pkg::SRC_CTRL: word = {{(apb_pkg::APB_DATA_W-1){1'b0}}, i_enable};
			clint_pkg::SRC_MTIME: begin
				if (i_rd_sel.sel == clint_pkg::RSEL_HI) begin
					word = i_mtime[clint_pkg::MTIME_W-1:apb_pkg::APB_DATA_W];
				end else begin
					word = i_mtime[apb_pkg::APB_DATA_W-1:0];
				end
			end
			clint_pkg::SRC_HART: begin
				if (i_rd_sel.sel == clint_pkg::RSEL_BIT) begin
					word = {{(apb_pkg::APB_DATA_W-1){1'b0}}, i_msip[i_rd_sel.hart]};
				end else if (i_rd_sel.sel == clint_pkg::RSEL_HI) begin
					word = cmp_sel[clint_pkg::MTIME_W-1:apb_pkg::APB_DATA_W];
				end else begin
					word = cmp_sel[apb_pkg::APB_DATA_W-1:0];
				end
			end
			default: word = '0;
		endcase
	end

	// never stalls
	assign o_apb.prdata  = word;
	assign o_apb.pready  = 1'b1;
	assign o_apb.pslverr = i_err;

endmodule

`default_nettype wire

/* source/clint_top.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  apb_pkg::apb_req_t              i_apb,
	input  logic                           i_dbg_halt,
	output apb_pkg::apb_rsp_t              o_apb,
	output logic [clint_pkg::N_HARTS-1:0]  o_timer_irq,
	output logic [clint_pkg::N_HARTS-1:0]  o_soft_irq
);

	clint_pkg::tb_wr_t                             tb_wr;
	clint_pkg::hart_wr_t [clint_pkg::N_HARTS-1:0]  hart_wr;
	clint_pkg::rd_sel_t                            rd_sel;
	logic                                          dec_err;
	logic                                          enable;
	logic [clint_pkg::MTIME_W-1:0]                 mtime;
	logic [clint_pkg::N_HARTS-1:0][clint_pkg::MTIME_W-1:0] mtimecmp;

	// --------------------------------------------------------------------------
	// address decode, only place paddr is looked at
	clint_apb_decode decode_u (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_apb     (i_apb),
		.o_tb_wr   (tb_wr),
		.o_hart_wr (hart_wr),
		.o_rd_sel  (rd_sel),
		.o_err     (dec_err)
	);

	// shared microsecond count
	clint_timebase timebase_u (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_wr       (tb_wr),
		.i_dbg_halt (i_dbg_halt),
		.o_mtime    (mtime),
		.o_enable   (enable)
	);

	// one compare unit per hart
	// msip goes straight out as the soft irq
	for (genvar h = 0; h < clint_pkg::N_HARTS; h++) begin : g_hart
		clint_hart_cmp cmp_u (
			.clk         (clk),
			.rst_n       (rst_n),
			.i_wr        (hart_wr[h]),
			.i_mtime     (mtime),
			.o_mtimecmp  (mtimecmp[h]),
			.o_msip      (o_soft_irq[h]),
			.o_timer_irq (o_timer_irq[h])
		);
	end

	// read data back onto the bus
	clint_read_mux read_mux_u (
		.i_rd_sel   (rd_sel),
		.i_err      (dec_err),
		.i_enable   (enable),
		.i_mtime    (mtime),
		.i_mtimecmp (mtimecmp),
		.i_msip     (o_soft_irq),
		.o_apb      (o_apb)
	);

endmodule

`default_nettype wire

/* tests/clint_props.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_props (
	input logic                          clk,
	input logic                          rst_n,
	input logic [clint_pkg::MTIME_W-1:0] i_mtime,
	input logic [clint_pkg::MTIME_W-1:0] i_mtimecmp,
	input logic                          i_msip,
	input logic                          i_timer_irq,
	input logic                          i_pready
);

	// --------------------------------------------------------------------------
	// bus side
	// zero wait state slave
	a_pready_high: assert property (@(posedge clk) disable iff (!rst_n) i_pready)
		else $error("pready dropped low");

	// --------------------------------------------------------------------------
	// compare unit
	// irq is the compare result one edge late
	a_timer_irq_reg: assert property (@(posedge clk) disable iff (!rst_n)
		i_timer_irq == $past(i_mtime >= i_mtimecmp))
		else $error("timer irq does not follow the registered compare");

	// both irq lines quiet in reset
	a_irq_in_reset: assert property (@(posedge clk)
		!rst_n |-> (!i_timer_irq && !i_msip))
		else $error("irq line high while in reset");

endmodule

`default_nettype wire

/* tests/clint_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module clint_tb;

	localparam int          CLK_PERIOD = 20;
	localparam int          RST_CYCLES = 3;
	localparam int          WD_MARGIN  = 50;
	localparam logic [31:0] SEED       = 32'h0520_db9f;

	typedef enum logic [2:0] {OP_WR, OP_RD, OP_WR_RND, OP_RD_RND, OP_WAIT, OP_HALT} op_e;

	// data field carries wdata, wait count or halt level
	typedef struct packed {
		op_e                           op;
		logic [15:0]                   addr;
		logic [31:0]                   data;
		logic [31:0]                   exp;
		logic [31:0]                   tol;
		logic                          err;
		logic                          chk_irq;
		logic [clint_pkg::N_HARTS-1:0] tirq;
		logic [clint_pkg::N_HARTS-1:0] sirq;
	} row_t;

	logic                          clk = 1'b0;
	logic                          rst_n;
	logic                          dbg_halt;
	apb_pkg::apb_req_t             apb_req;
	apb_pkg::apb_rsp_t             apb_rsp;
	logic [clint_pkg::N_HARTS-1:0] timer_irq;
	logic [clint_pkg::N_HARTS-1:0] soft_irq;

	row_t        tbl [0:127];
	int          n_rows        = 0;
	int          budget_cycles = 0;
	logic [31:0] lfsr_q;
	logic [31:0] scratch [$];
	bit          run_ended     = 1'b0;

	clint_top clint_top_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_apb       (apb_req),
		.i_dbg_halt  (dbg_halt),
		.o_apb       (apb_rsp),
		.o_timer_irq (timer_irq),
		.o_soft_irq  (soft_irq)
	);

	bind clint_hart_cmp clint_props props_i (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_mtime     (i_mtime),
		.i_mtimecmp  (o_mtimecmp),
		.i_msip      (o_msip),
		.i_timer_irq (o_timer_irq),
		.i_pready    (clint_tb.clint_top_i.o_apb.pready)
	);

	initial begin
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// --------------------------------------------------------------------------
	// scratch data from x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// one step per bit taken
	task automatic next_rand(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr_q = lfsr_step(lfsr_q);
			w      = {w[30:0], lfsr_q[0]};
		end
	endtask

	function automatic logic [15:0] hart_addr(input int h, input logic [15:0] off);
		return 16'(clint_pkg::HART_BASE + h * clint_pkg::HART_STRIDE + off);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, exp, tol);
		logic [31:0] diff;
		diff = (got >= exp) ? got - exp : exp - got;
		assert (diff <= tol) else begin
			run_ended = 1'b1;
			$display("MISMATCH time=%0t %s expected=%h actual=%h", $time, name, exp, got);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	// --------------------------------------------------------------------------
	// table construction
	task automatic push_row(input op_e op, input logic [15:0] addr,
			input logic [31:0] data, exp, tol, input logic err);
		row_t r;
		r      = '0;
		r.op   = op;
		r.addr = addr;
		r.data = data;
		r.exp  = exp;
		r.tol  = tol;
		r.err  = err;
		tbl[n_rows] = r;
		n_rows++;
	endtask

	// writes return zero data
	task automatic push_write(input logic [15:0] addr, input logic [31:0] data);
		push_row(OP_WR, addr, data, 0, 0, 1'b0);
	endtask

	task automatic push_read(input logic [15:0] addr, input logic [31:0] exp, tol);
		push_row(OP_RD, addr, 0, exp, tol, 1'b0);
	endtask

	// irq vectors checked on the last row pushed
	task automatic push_irq_check(input logic [clint_pkg::N_HARTS-1:0] tirq, sirq);
		tbl[n_rows-1].chk_irq = 1'b1;
		tbl[n_rows-1].tirq    = tirq;
		tbl[n_rows-1].sirq    = sirq;
	endtask

	task automatic build_table();
		// reset values
		push_read(clint_pkg::REG_CTRL, 0, 0);
		push_irq_check(2'b00, 2'b00);
		push_read(clint_pkg::REG_MTIME_LO, 0, 0);
		push_read(clint_pkg::REG_MTIME_HI, 0, 0);
		for (int h = 0; h < clint_pkg::N_HARTS; h++) begin
			push_read(hart_addr(h, clint_pkg::HREG_MSIP), 0, 0);
			push_read(hart_addr(h, clint_pkg::HREG_CMP_LO), 32'hffff_ffff, 0);
			push_read(hart_addr(h, clint_pkg::HREG_CMP_HI), 32'hffff_ffff, 0);
		end
		// lfsr words read back in write order
		for (int h = 0; h < clint_pkg::N_HARTS; h++) begin
			push_row(OP_WR_RND, hart_addr(h, clint_pkg::HREG_CMP_LO), 0, 0, 0, 1'b0);
			push_row(OP_WR_RND, hart_addr(h, clint_pkg::HREG_CMP_HI), 0, 0, 0, 1'b0);
			push_row(OP_RD_RND, hart_addr(h, clint_pkg::HREG_CMP_LO), 0, 0, 0, 1'b0);
			push_row(OP_RD_RND, hart_addr(h, clint_pkg::HREG_CMP_HI), 0, 0, 0, 1'b0);
			push_write(hart_addr(h, clint_pkg::HREG_MSIP), 1);
			push_read(hart_addr(h, clint_pkg::HREG_MSIP), 1, 0);
			push_irq_check(2'b00, 2'b01 << h);
			push_write(hart_addr(h, clint_pkg::HREG_MSIP), 0);
			push_read(hart_addr(h, clint_pkg::HREG_MSIP), 0, 0);
			push_irq_check(2'b00, 2'b00);
		end
		// counting spans wait + 1 edges from enable to sample
		push_write(clint_pkg::REG_MTIME_HI, 32'h12);
		push_write(clint_pkg::REG_MTIME_LO, 32'h100);
		push_write(clint_pkg::REG_CTRL, 1);
		push_row(OP_WAIT, 0, 18, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_LO, 32'h100 + 19 / clint_pkg::TICK_DIV, 1);
		push_read(clint_pkg::REG_MTIME_HI, 32'h12, 0);
		push_read(clint_pkg::REG_CTRL, 1, 0);
		// carry into the upper half
		push_write(clint_pkg::REG_CTRL, 0);
		push_write(clint_pkg::REG_MTIME_HI, 0);
		push_write(clint_pkg::REG_MTIME_LO, 32'hffff_fffe);
		push_write(clint_pkg::REG_CTRL, 1);
		push_row(OP_WAIT, 0, 18, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_HI, 1, 0);
		push_read(clint_pkg::REG_MTIME_LO, 32'hffff_fffe + 21 / clint_pkg::TICK_DIV, 1);
		// timer irq on hart 0 with hart 1 parked at all ones
		push_write(clint_pkg::REG_CTRL, 0);
		push_write(clint_pkg::REG_MTIME_LO, 32'h200);
		push_write(clint_pkg::REG_MTIME_HI, 0);
		push_write(hart_addr(1, clint_pkg::HREG_CMP_LO), 32'hffff_ffff);
		push_write(hart_addr(1, clint_pkg::HREG_CMP_HI), 32'hffff_ffff);
		push_write(hart_addr(0, clint_pkg::HREG_CMP_LO), 32'h203);
		push_write(hart_addr(0, clint_pkg::HREG_CMP_HI), 0);
		push_read(hart_addr(0, clint_pkg::HREG_CMP_LO), 32'h203, 0);
		push_irq_check(2'b00, 2'b00);
		push_write(clint_pkg::REG_CTRL, 1);
		push_row(OP_WAIT, 0, 6, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_LO, 32'h200 + 7 / clint_pkg::TICK_DIV, 1);
		push_irq_check(2'b00, 2'b00);
		push_row(OP_WAIT, 0, 12, 0, 0, 1'b0);
		// mtime past 0x203 several edges ago
		push_read(clint_pkg::REG_MTIME_LO, 32'h200 + 21 / clint_pkg::TICK_DIV, 1);
		push_irq_check(2'b01, 2'b00);
		push_write(hart_addr(0, clint_pkg::HREG_CMP_LO), 32'hffff_ffff);
		push_write(hart_addr(0, clint_pkg::HREG_CMP_HI), 32'hffff_ffff);
		push_read(hart_addr(0, clint_pkg::HREG_CMP_HI), 32'hffff_ffff, 0);
		push_irq_check(2'b00, 2'b00);
		// debug halt freezes divider and mtime
		push_write(clint_pkg::REG_CTRL, 0);
		push_write(clint_pkg::REG_MTIME_LO, 32'h40);
		push_write(clint_pkg::REG_CTRL, 1);
		push_row(OP_HALT, 0, 1, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_LO, 32'h40, 0);
		push_row(OP_WAIT, 0, 12, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_LO, 32'h40, 0);
		push_row(OP_HALT, 0, 0, 0, 0, 1'b0);
		push_row(OP_WAIT, 0, 18, 0, 0, 1'b0);
		push_read(clint_pkg::REG_MTIME_LO, 32'h40 + 20 / clint_pkg::TICK_DIV, 1);
		// unmapped offsets and hart index N_HARTS
		push_row(OP_RD, 16'h0004, 0, 0, 0, 1'b1);
		push_row(OP_WR, 16'h0004, 32'hdead_beef, 0, 0, 1'b1);
		push_row(OP_RD, hart_addr(clint_pkg::N_HARTS, clint_pkg::HREG_CMP_LO), 0, 0, 0, 1'b1);
		push_row(OP_WR, hart_addr(clint_pkg::N_HARTS, clint_pkg::HREG_CMP_LO), 1, 0, 0, 1'b1);
		push_row(OP_WR, hart_addr(clint_pkg::N_HARTS, clint_pkg::HREG_MSIP), 1, 0, 0, 1'b1);
		// no aliasing onto hart 0
		push_read(clint_pkg::REG_CTRL, 1, 0);
		push_read(hart_addr(0, clint_pkg::HREG_CMP_LO), 32'hffff_ffff, 0);
		push_read(hart_addr(0, clint_pkg::HREG_MSIP), 0, 0);
		push_irq_check(2'b00, 2'b00);
	endtask

	// --------------------------------------------------------------------------
	// each row starts and ends on a falling edge
	task automatic apply_row(input row_t r);
		logic [31:0] wdata;
		logic [31:0] exp;
		case (r.op)
			OP_WAIT: repeat (r.data) @(negedge clk);
			OP_HALT: begin
				dbg_halt = r.data[0];
				@(negedge clk);
			end
			default: begin
				wdata = r.data;
				exp   = r.exp;
				if (r.op == OP_WR_RND) begin
					next_rand(wdata);
					scratch.push_back(wdata);
				end
				if (r.op == OP_RD_RND) begin
					exp = scratch.pop_front();
				end
				// setup phase
				apb_req.psel    = 1'b1;
				apb_req.penable = 1'b0;
				apb_req.pwrite  = (r.op == OP_WR || r.op == OP_WR_RND);
				apb_req.paddr   = r.addr;
				apb_req.pwdata  = wdata;
				@(negedge clk);
				// access phase sampled mid low phase
				apb_req.penable = 1'b1;
				#(CLK_PERIOD / 4);
				check_value("prdata", apb_rsp.prdata, exp, r.tol);
				check_value("pslverr", 32'(apb_rsp.pslverr), 32'(r.err), 0);
				check_value("pready", 32'(apb_rsp.pready), 1, 0);
				if (r.chk_irq) begin
					check_value("o_timer_irq", 32'(timer_irq), 32'(r.tirq), 0);
					check_value("o_soft_irq", 32'(soft_irq), 32'(r.sirq), 0);
				end
				@(negedge clk);
				apb_req = '0;
			end
		endcase
	endtask

	initial begin
		rst_n    = 1'b0;
		dbg_halt = 1'b0;
		apb_req  = '0;
		lfsr_q   = SEED;
		build_table();
		for (int i = 0; i < n_rows; i++) begin
			if (tbl[i].op == OP_WAIT) begin
				budget_cycles += tbl[i].data;
			end else begin
				budget_cycles += (tbl[i].op == OP_HALT) ? 1 : 2;
			end
		end
		repeat (RST_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		for (int i = 0; i < n_rows; i++) begin
			apply_row(tbl[i]);
		end
		run_ended = 1'b1;
		$display("Test passed");
		$finish;
	end

	// watchdog sized from the table
	initial begin
		wait (budget_cycles > 0);
		#((budget_cycles + RST_CYCLES + WD_MARGIN) * CLK_PERIOD);
		run_ended = 1'b1;
		$display("watchdog expired before the stimulus table was done");
		$display("Test failed");
		$fatal(1);
	end

	// stopped early by an assertion in the bound checker
	final begin
		if (!run_ended) begin
			$display("simulation stopped before the stimulus table was done");
			$display("Test failed");
		end
	end

endmodule

`default_nettype wire

/* sim.f */
source/apb_pkg.sv
source/clint_pkg.sv
source/clint_timebase.sv
source/clint_hart_cmp.sv
source/clint_apb_decode.sv
source/clint_read_mux.sv
source/clint_top.sv
tests/clint_props.sv
tests/clint_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the CLINT testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --timescale 1ns/100ps -f sim.f \
	--top-module clint_tb -o clint_sim; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/clint_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Test passed"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1
